// File: common/csi2_decomp_settings.svh
`ifndef CSI2_DECOMP_SETTINGS_SVH
`define CSI2_DECOMP_SETTINGS_SVH

// Datapath widths
`define CODE_W 8 // Compressed code
`define PIX_W 12 // Widest reconstructed pixel
`define POS_W 16 // Line length and position

`define HIST_DEPTH 4 // Pixels kept for prediction

// Saturation limits per output depth
`define PIX_MAX_10 1023
`define PIX_MAX_12 4095

// Format field of config_reg[2:0]
`define FMT_10_8_10 3
`define FMT_12_8_12 6

`endif

// File: common/csi2_decomp_pkg.sv
`include "csi2_decomp_settings.svh"

package csi2_decomp_pkg;

  typedef logic [`CODE_W-1:0] code_t; // One compressed code
  typedef logic [`PIX_W-1:0]  pixel_t; // One reconstructed pixel
  typedef logic [`POS_W-1:0]  pos_t; // Line length or position

  // Supported compression formats, values as in config_reg[2:0]
  typedef enum logic [2:0]
  {
    FMT_10 = `FMT_10_8_10,
    FMT_12 = `FMT_12_8_12
  } fmt_e;

  // Predictor in use
  typedef enum logic
  {
    PRED2 = 1'b0,
    PRED1 = 1'b1
  } pred_e;

endpackage

// File: source/decomp_cfg_regs.sv
module decomp_cfg_regs import csi2_decomp_pkg::*;
(
  input  logic       enc_data_vld,
  input  logic       rst,
  input  logic       cfg_wr,
  input  logic [4:0] config_reg,
  input  pos_t       num_pxls_per_line,
  output fmt_e       fmt,
  output pred_e      pred_sel,
  output pos_t       line_len,
  output logic       cfg_ok
);

  fmt_e  fmt_q;
  pred_e pred_q;
  pos_t  line_len_q;

  always_ff @(posedge enc_data_vld)
  begin
    if (rst)
    begin
      fmt_q      <= fmt_e'(3'b000); // Unsupported, keeps cfg_ok low
      pred_q     <= PRED1;
      line_len_q <= '0;
    end
    else if (cfg_wr)
    begin
      fmt_q      <= fmt_e'(config_reg[2:0]);
      pred_q     <= config_reg[3] ? PRED1 : PRED2; // Bit 3 set selects predictor 1
      line_len_q <= num_pxls_per_line;
    end
  end

  // Decoding needs a known format and room for the two start pixels
  always_comb
  begin
    cfg_ok = ((fmt_q == FMT_10) || (fmt_q == FMT_12)) && (line_len_q >= pos_t'(2));
  end

  assign fmt      = fmt_q;
  assign pred_sel = pred_q;
  assign line_len = line_len_q;

  // cfg_ok only comes up after a write of a supported format
  a_cfg_ok_fmt : assert property (
    @(posedge enc_data_vld) disable iff (rst)
    $rose(cfg_ok) |-> ($past(cfg_wr) && ($past(config_reg[2:0]) inside {FMT_10, FMT_12}))
  );

endmodule

// File: decoder/line_tracker.sv
module line_tracker import csi2_decomp_pkg::*;
(
  input  logic enc_data_vld,
  input  logic rst,
  input  logic cfg_wr,
  input  logic take,
  input  pos_t line_len,
  output pos_t pos,
  output logic first_pxl,
  output logic scnd_pxl
);

  pos_t pos_q;
  logic last_pxl;

  assign last_pxl = (pos_q >= line_len - pos_t'(1)); // Last code of the line

  always_ff @(posedge enc_data_vld)
  begin
    if (rst)
    begin
      pos_q <= '0;
    end
    else if (cfg_wr)
    begin
      pos_q <= '0; // New geometry restarts the line
    end
    else if (take)
    begin
      if (last_pxl)
      begin
        pos_q <= '0;
      end
      else
      begin
        pos_q <= pos_q + pos_t'(1);
      end
    end
  end

  assign pos       = pos_q;
  assign first_pxl = (pos_q == pos_t'(0));
  assign scnd_pxl  = (pos_q == pos_t'(1));

  // Codes only arrive with a valid config, so the count stays inside the line
  a_pos_in_line : assert property (
    @(posedge enc_data_vld) disable iff (rst)
    take |-> (pos_q < line_len)
  );

endmodule

// File: decoder/pixel_predictor.sv
`include "csi2_decomp_settings.svh"

module pixel_predictor import csi2_decomp_pkg::*;
(
  input  logic   enc_data_vld,
  input  logic   rst,
  input  pred_e  pred_sel,
  input  pos_t   pos,
  input  pixel_t new_pix,
  input  logic   new_pix_vld,
  output pixel_t pred
);

  pixel_t           hist [`HIST_DEPTH]; // Index 0 is the most recent pixel
  pixel_t           p1;
  pixel_t           p2;
  pixel_t           p3;
  pixel_t           p4;
  logic             mono;
  logic             same_side;
  logic [`PIX_W:0]  mean_sum;
  pixel_t           pred2;

  // History shift, one entry per decoded pixel
  always_ff @(posedge enc_data_vld)
  begin
    if (rst)
    begin
      for (int i = 0; i < `HIST_DEPTH; i++)
      begin
        hist[i] <= '0;
      end
    end
    else if (new_pix_vld)
    begin
      hist[0] <= new_pix;
      for (int i = 1; i < `HIST_DEPTH; i++)
      begin
        hist[i] <= hist[i-1];
      end
    end
  end

  assign p1 = hist[0];
  assign p2 = hist[1];
  assign p3 = hist[2];
  assign p4 = hist[3];

  // p1, p2, p3 run in one direction
  assign mono = ((p1 <= p2) && (p2 <= p3)) || ((p1 >= p2) && (p2 >= p3));

  // p1 relates to p3 as p2 relates to p4
  assign same_side = ((p1 <= p3) && (p2 <= p4)) || ((p1 >= p3) && (p2 >= p4));

  assign mean_sum = {1'b0, p2} + {1'b0, p4} + 1'b1; // Rounded mean, one bit of headroom

  always_comb
  begin
    case (pos)
      pos_t'(0) : pred2 = p1; // Raw pixel, prediction not used
      pos_t'(1) : pred2 = p1;
      pos_t'(2) : pred2 = p2;
      pos_t'(3) : pred2 = mono ? p1 : p2;
      default :
      begin
        if (mono)
        begin
          pred2 = p1;
        end
        else if (same_side)
        begin
          pred2 = p2;
        end
        else
        begin
          pred2 = mean_sum[`PIX_W:1];
        end
      end
    endcase
  end

  assign pred = (pred_sel == PRED1) ? p2 : pred2; // Predictor 1 is always two back

endmodule

// File: decoder/dpcm_decoder.sv
`include "csi2_decomp_settings.svh"

module dpcm_decoder import csi2_decomp_pkg::*;
(
  input  logic   enc_data_vld,
  input  logic   rst,
  input  logic   code_vld,
  input  logic   cfg_ok,
  input  code_t  enc_data_ip,
  input  fmt_e   fmt,
  input  pred_e  pred_sel,
  input  logic   first_pxl,
  input  logic   scnd_pxl,
  input  pixel_t pred,
  output logic   take,
  output pixel_t new_pix,
  output logic   new_pix_vld,
  output pixel_t dec_data_op,
  output logic   dec_data_vld
);

  logic            is_12;
  logic            is_raw;
  logic            is_pcm;
  logic            neg;
  pixel_t          mag;
  pixel_t          pix_max;
  pixel_t          raw_pix;
  pixel_t          pcm_v;
  pixel_t          pcm_pix;
  pixel_t          dpcm_pix;
  logic [`PIX_W:0] sum;
  logic [`PIX_W:0] diff;
  pixel_t          pix;

  assign take   = code_vld & cfg_ok;
  assign is_12  = (fmt == FMT_12);
  assign is_raw = first_pxl | (scnd_pxl & (pred_sel == PRED1)); // Unpredicted start of line

  assign pix_max = is_12 ? pixel_t'(`PIX_MAX_12) : pixel_t'(`PIX_MAX_10);

  // Raw pixel sits in the middle of its quantization step
  assign raw_pix = is_12 ? {enc_data_ip, 4'd8} : {2'b00, enc_data_ip, 2'd2};

  // Class decode, magnitude and sign of the step
  always_comb
  begin
    is_pcm = enc_data_ip[7];
    mag    = '0;
    neg    = 1'b0;
    if (!is_12)
    begin
      casez (enc_data_ip[7:5])
        3'b00? :
        begin
          mag = pixel_t'(enc_data_ip[4:0]); // DPCM1
          neg = enc_data_ip[5];
        end
        3'b010 :
        begin
          mag = pixel_t'({enc_data_ip[3:0], 1'b0}) + pixel_t'(32); // DPCM2
          neg = enc_data_ip[4];
        end
        3'b011 :
        begin
          mag = pixel_t'({enc_data_ip[3:0], 2'b00}) + pixel_t'(65); // DPCM3
          neg = enc_data_ip[4];
        end
        default : ;
      endcase
    end
    else
    begin
      casez (enc_data_ip[7:4])
        4'b0000 :
        begin
          mag = pixel_t'(enc_data_ip[2:0]); // DPCM1
          neg = enc_data_ip[3];
        end
        4'b011? :
        begin
          mag = pixel_t'({enc_data_ip[3:0], 1'b0}) + pixel_t'(8); // DPCM2
          neg = enc_data_ip[4];
        end
        4'b010? :
        begin
          mag = pixel_t'({enc_data_ip[3:0], 2'b00}) + pixel_t'(41); // DPCM3
          neg = enc_data_ip[4];
        end
        4'b001? :
        begin
          mag = pixel_t'({enc_data_ip[3:0], 3'b000}) + pixel_t'(107); // DPCM4
          neg = enc_data_ip[4];
        end
        4'b0001 :
        begin
          mag = pixel_t'({enc_data_ip[2:0], 4'b0000}) + pixel_t'(239); // DPCM5
          neg = enc_data_ip[3];
        end
        default : ;
      endcase
    end
  end

  // Extra bit catches the overflow and the borrow
  assign sum  = {1'b0, pred} + {1'b0, mag};
  assign diff = {1'b0, pred} - {1'b0, mag};

  always_comb
  begin
    if (neg)
    begin
      dpcm_pix = diff[`PIX_W] ? '0 : diff[`PIX_W-1:0]; // Clamp at black
    end
    else if (sum > {1'b0, pix_max})
    begin
      dpcm_pix = pix_max; // Clamp at full scale
    end
    else
    begin
      dpcm_pix = sum[`PIX_W-1:0];
    end
  end

  // PCM keeps the top bits, the offset depends on where the prediction lies
  assign pcm_v   = is_12 ? {enc_data_ip[6:0], 5'b00000} : {2'b00, enc_data_ip[6:0], 3'b000};
  assign pcm_pix = pcm_v + (is_12 ? pixel_t'(15) : pixel_t'(3))
                   + ((pcm_v <= pred) ? pixel_t'(1) : pixel_t'(0));

  always_comb
  begin
    if (is_raw)
    begin
      pix = raw_pix;
    end
    else if (is_pcm)
    begin
      pix = pcm_pix;
    end
    else
    begin
      pix = dpcm_pix;
    end
  end

  // Predictor history takes the pixel at the same edge as the output register
  assign new_pix     = pix;
  assign new_pix_vld = take;

  always_ff @(posedge enc_data_vld)
  begin
    if (rst)
    begin
      dec_data_op  <= '0;
      dec_data_vld <= 1'b0;
    end
    else
    begin
      dec_data_vld <= take;
      if (take)
      begin
        dec_data_op <= pix;
      end
    end
  end

  // Format of the decoded code, not the current one, bounds the output
  a_range_10 : assert property (
    @(posedge enc_data_vld) disable iff (rst)
    (dec_data_vld && ($past(fmt) == FMT_10)) |-> (dec_data_op <= pixel_t'(`PIX_MAX_10))
  );

endmodule

// File: source/csi2_decomp_top.sv
module csi2_decomp_top import csi2_decomp_pkg::*;
(
  input  logic       enc_data_vld,
  input  logic       rst,
  input  logic       cfg_wr,
  input  logic [4:0] config_reg,
  input  pos_t       num_pxls_per_line,
  input  logic       code_vld,
  input  code_t      enc_data_ip,
  output pixel_t     dec_data_op,
  output logic       dec_data_vld
);

  fmt_e   fmt;
  pred_e  pred_sel;
  pos_t   line_len;
  logic   cfg_ok;
  pos_t   pos;
  logic   first_pxl;
  logic   scnd_pxl;
  logic   take;
  pixel_t pred;
  pixel_t new_pix;
  logic   new_pix_vld;

  decomp_cfg_regs i_decomp_cfg_regs (
    .enc_data_vld      (enc_data_vld),
    .rst               (rst),
    .cfg_wr            (cfg_wr),
    .config_reg        (config_reg),
    .num_pxls_per_line (num_pxls_per_line),
    .fmt               (fmt),
    .pred_sel          (pred_sel),
    .line_len          (line_len),
    .cfg_ok            (cfg_ok)
  );

  line_tracker i_line_tracker (
    .enc_data_vld (enc_data_vld),
    .rst          (rst),
    .cfg_wr       (cfg_wr),
    .take         (take),
    .line_len     (line_len),
    .pos          (pos),
    .first_pxl    (first_pxl),
    .scnd_pxl     (scnd_pxl)
  );

  pixel_predictor i_pixel_predictor (
    .enc_data_vld (enc_data_vld),
    .rst          (rst),
    .pred_sel     (pred_sel),
    .pos          (pos),
    .new_pix      (new_pix),
    .new_pix_vld  (new_pix_vld),
    .pred         (pred)
  );

  dpcm_decoder i_dpcm_decoder (
    .enc_data_vld (enc_data_vld),
    .rst          (rst),
    .code_vld     (code_vld),
    .cfg_ok       (cfg_ok),
    .enc_data_ip  (enc_data_ip),
    .fmt          (fmt),
    .pred_sel     (pred_sel),
    .first_pxl    (first_pxl),
    .scnd_pxl     (scnd_pxl),
    .pred         (pred),
    .take         (take),
    .new_pix      (new_pix),
    .new_pix_vld  (new_pix_vld),
    .dec_data_op  (dec_data_op),
    .dec_data_vld (dec_data_vld)
  );

endmodule

// File: verif/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Full scale of the selected output depth
function automatic int ref_full_scale(input bit fmt12);
  return fmt12 ? `PIX_MAX_12 : `PIX_MAX_10;
endfunction

// Unpredicted pixel in the middle of its step
function automatic int ref_raw(input bit fmt12, input bit [7:0] code);
  return fmt12 ? (int'(code) * 16 + 8) : (int'(code) * 4 + 2);
endfunction

function automatic bit ref_monotone(input int a, input int b, input int c);
  return ((a <= b) && (b <= c)) || ((a >= b) && (b >= c));
endfunction

// p1 is the most recent pixel of the line
function automatic int ref_predict(input bit pred1, input int pos, input int p1,
                                   input int p2, input int p3, input int p4);
  if (pred1)
    return p2; // Two pixels back
  if (pos <= 1)
    return p1;
  if (pos == 2)
    return p2;
  if (ref_monotone(p1, p2, p3))
    return p1;
  if (pos == 3)
    return p2;
  if (((p1 <= p3) && (p2 <= p4)) || ((p1 >= p3) && (p2 >= p4)))
    return p2;
  return (p2 + p4 + 1) / 2; // Rounded mean
endfunction

function automatic int ref_decode(input bit fmt12, input bit [7:0] code, input int pred,
                                  input bit raw);
  int mag;
  bit neg;
  int base;
  int res;
  if (raw)
    return ref_raw(fmt12, code);
  if (code[7])
  begin
    base = fmt12 ? (int'(code[6:0]) * 32) : (int'(code[6:0]) * 8); // PCM
    res  = base + (fmt12 ? 15 : 3);
    if (base <= pred)
      res = res + 1;
    return res;
  end
  neg = code[4];
  if (!fmt12)
  begin
    if (code[7:6] == 2'b00)
    begin
      mag = int'(code[4:0]);
      neg = code[5];
    end
    else if (code[7:5] == 3'b010)
      mag = int'(code[3:0]) * 2 + 32;
    else
      mag = int'(code[3:0]) * 4 + 65;
  end
  else
  begin
    if (code[7:4] == 4'b0000)
    begin
      mag = int'(code[2:0]);
      neg = code[3];
    end
    else if (code[7:4] == 4'b0001)
    begin
      mag = int'(code[2:0]) * 16 + 239;
      neg = code[3];
    end
    else if (code[7:5] == 3'b001)
      mag = int'(code[3:0]) * 8 + 107;
    else if (code[7:5] == 3'b010)
      mag = int'(code[3:0]) * 4 + 41;
    else
      mag = int'(code[3:0]) * 2 + 8;
  end
  res = neg ? (pred - mag) : (pred + mag);
  if (res < 0)
    res = 0;
  if (res > ref_full_scale(fmt12))
    res = ref_full_scale(fmt12);
  return res;
endfunction

`endif

// File: verif/tb_csi2_decomp.sv
`include "csi2_decomp_settings.svh"

module tb_csi2_decomp import csi2_decomp_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic       enc_data_vld      = 1'b0;
  logic       rst               = 1'b1;
  logic       cfg_wr            = 1'b0;
  logic [4:0] config_reg        = '0;
  pos_t       num_pxls_per_line = '0;
  logic       code_vld          = 1'b0;
  code_t      enc_data_ip       = '0;
  pixel_t     dec_data_op;
  logic       dec_data_vld;

  // Model state
  int    mdl_hist [4];
  int    mdl_pos   = 0;
  int    mdl_len   = 0;
  bit    mdl_fmt12 = 1'b0;
  bit    mdl_pred1 = 1'b0;
  bit    mdl_ok    = 1'b0;
  int    exp_q [$]; // Expected pixels in order
  int    stamp_q [$]; // Cycle of each accepted code
  int    cycle_cnt = 0;
  int    exp_pix;
  int    stamp;
  string cur_test  = "reset";

  `include "tb_ref_model.svh"

  csi2_decomp_top i_csi2_decomp_top (
    .enc_data_vld      (enc_data_vld),
    .rst               (rst),
    .cfg_wr            (cfg_wr),
    .config_reg        (config_reg),
    .num_pxls_per_line (num_pxls_per_line),
    .code_vld          (code_vld),
    .enc_data_ip       (enc_data_ip),
    .dec_data_op       (dec_data_op),
    .dec_data_vld      (dec_data_vld)
  );

  initial
  begin
    forever
    begin
      #10 enc_data_vld = ~enc_data_vld; // 20 ns period
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // Output check in the stable half of the cycle
  always @(negedge enc_data_vld)
  begin
    if ((rst === 1'b0) && (dec_data_vld === 1'b1))
    begin
      assert (exp_q.size() > 0)
      else stop_on_error($sformatf("Unexpected dec_data_vld in test %s", cur_test));
      exp_pix = exp_q.pop_front();
      stamp   = stamp_q.pop_front();
      assert (cycle_cnt == stamp + 1)
      else stop_on_error($sformatf("Fail %s latency expected 1 actual %0d",
                                   cur_test, cycle_cnt - stamp));
      assert (dec_data_op == pixel_t'(exp_pix))
      else stop_on_error($sformatf("Fail %s expected %0d actual %0d",
                                   cur_test, exp_pix, dec_data_op));
    end
    cycle_cnt++;
  end

  task automatic write_cfg(input logic [4:0] cfg, input int len);
    @(posedge enc_data_vld);
    cfg_wr            <= 1'b1;
    config_reg        <= cfg;
    num_pxls_per_line <= pos_t'(len);
    code_vld          <= 1'b0;
    @(posedge enc_data_vld);
    cfg_wr <= 1'b0;
    mdl_fmt12 = (cfg[2:0] == `FMT_12_8_12);
    mdl_pred1 = cfg[3];
    mdl_len   = len;
    mdl_pos   = 0; // Line restarts on a config write
    mdl_ok    = ((cfg[2:0] == `FMT_10_8_10) || (cfg[2:0] == `FMT_12_8_12)) && (len >= 2);
  endtask

  // One code per call, consecutive calls run back-to-back
  task automatic send_code(input bit [7:0] code);
    int pred;
    int pix;
    bit raw;
    @(posedge enc_data_vld);
    code_vld    <= 1'b1;
    enc_data_ip <= code;
    if (mdl_ok)
    begin
      raw  = (mdl_pos == 0) || ((mdl_pos == 1) && mdl_pred1);
      pred = ref_predict(mdl_pred1, mdl_pos, mdl_hist[0], mdl_hist[1], mdl_hist[2],
                         mdl_hist[3]);
      pix  = ref_decode(mdl_fmt12, code, pred, raw);
      exp_q.push_back(pix);
      stamp_q.push_back(cycle_cnt);
      mdl_hist[3] = mdl_hist[2];
      mdl_hist[2] = mdl_hist[1];
      mdl_hist[1] = mdl_hist[0];
      mdl_hist[0] = pix;
      mdl_pos = (mdl_pos + 1 >= mdl_len) ? 0 : mdl_pos + 1;
    end
  endtask

  task automatic end_burst();
    @(posedge enc_data_vld);
    code_vld <= 1'b0;
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < max_cycles))
    begin
      @(negedge enc_data_vld);
      n++;
    end
    assert (exp_q.size() == 0)
    else stop_on_error($sformatf("Timeout waiting for dec_data_vld in test %s", cur_test));
  endtask

  task automatic send_list(input bit [7:0] codes [$]);
    foreach (codes[i])
    begin
      send_code(codes[i]);
    end
    end_burst();
    wait_drain(20);
  endtask

  task automatic test_no_config();
    cur_test = "no_config";
    @(negedge enc_data_vld);
    assert ((dec_data_vld == 1'b0) && (dec_data_op == '0))
    else stop_on_error("Outputs are not cleared after reset");
    send_list('{8'h12, 8'h80, 8'hff, 8'h45}); // cfg_ok low after reset
    write_cfg(5'b01001, 8); // Format 001 is not supported
    send_list('{8'h33, 8'h9a});
    write_cfg(5'b01011, 1); // Line too short
    send_list('{8'h21, 8'h07});
    repeat (4) @(posedge enc_data_vld);
  endtask

  task automatic test_fmt10_pred1();
    bit [7:0] codes [$];
    cur_test = "fmt10_pred1";
    write_cfg(5'b01011, 8);
    repeat (8) codes.push_back(8'($urandom));
    send_list(codes);
  endtask

  task automatic test_fmt12_pred2();
    cur_test = "fmt12_pred2";
    write_cfg(5'b00110, 8);
    // Raw, DPCM2, DPCM3, DPCM4, DPCM5 on the mean case, DPCM1, PCM, DPCM1
    send_list('{8'h80, 8'h65, 8'h5a, 8'h23, 8'h1a, 8'h05, 8'hc4, 8'h0b,
                8'h40, 8'h62, 8'h68, 8'ha0, 8'h03, 8'h17, 8'h35, 8'hff});
  endtask

  task automatic test_saturation();
    cur_test = "saturation_10";
    write_cfg(5'b00011, 4);
    send_list('{8'hff, 8'h6f, 8'h6f, 8'h7f, 8'h00, 8'h7f, 8'h7f, 8'h7f});
    cur_test = "saturation_12";
    write_cfg(5'b00110, 4);
    send_list('{8'hff, 8'h4f, 8'h4f, 8'h5f, 8'h00, 8'h5f, 8'h5f, 8'h5f});
  endtask

  task automatic test_line_wrap();
    bit [7:0] codes [$];
    cur_test = "line_wrap";
    write_cfg(5'b01011, 3);
    repeat (6) codes.push_back(8'($urandom)); // Two lines of three
    send_list(codes);
  endtask

  initial
  begin
    mdl_hist = '{default: 0};
    void'($urandom(78673));
    repeat (2) @(posedge enc_data_vld);
    rst <= 1'b0;
    test_no_config();
    test_fmt10_pred1();
    test_fmt12_pred2();
    test_saturation();
    test_line_wrap();
    repeat (2) @(posedge enc_data_vld);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: csi2_decomp_top.f
+incdir+common
+incdir+verif
common/csi2_decomp_pkg.sv
source/decomp_cfg_regs.sv
decoder/line_tracker.sv
decoder/pixel_predictor.sv
decoder/dpcm_decoder.sv
source/csi2_decomp_top.sv
verif/tb_csi2_decomp.sv

// File: Bender.yml
package:
  name: csi2_decomp

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/csi2_decomp_pkg.sv
      - source/decomp_cfg_regs.sv
      - decoder/line_tracker.sv
      - decoder/pixel_predictor.sv
      - decoder/dpcm_decoder.sv
      - source/csi2_decomp_top.sv
  - target: test
    include_dirs:
      - common
      - verif
    files:
      - verif/tb_csi2_decomp.sv
